// ==== source/dcache_pkg.sv ====
package dcache_pkg;

	// cache geometry, one 64-bit block per line
	localparam int cache_lines = 32;
	localparam int index_bits  = $clog2(cache_lines); // 5 for 32 lines
	localparam int offset_bits = 3; // byte offset inside a block
	localparam int addr_bits   = 16; // byte address space
	localparam int tag_bits    = addr_bits - index_bits - offset_bits;

	// command encoding shared by the processor and memory buses
	typedef enum logic [1:0] {
		bus_none  = 2'h0,
		bus_load  = 2'h1,
		bus_store = 2'h2
	} bus_cmd_e;

	// field view of a byte address, msb first
	typedef struct packed {
		logic [tag_bits-1:0]    tag;
		logic [index_bits-1:0]  index;
		logic [offset_bits-1:0] offset; // ignored, blocks are whole
	} addr_fields_t;

	// one address word, read raw or split into tag/index/offset
	typedef union packed {
		logic [addr_bits-1:0] raw;
		addr_fields_t         fields;
	} addr_u;

	// processor request, held stable while req is high
	typedef struct packed {
		bus_cmd_e    command;
		addr_u       addr;
		logic [63:0] data; // store data
	} cpu_req_t;

	// load result, valid while ack is high
	typedef struct packed {
		logic [63:0] data;
	} cpu_rsp_t;

	// cache to memory
	typedef struct packed {
		bus_cmd_e             command;
		logic [addr_bits-1:0] addr;
		logic [63:0]          data;
	} mem_req_t;

	// memory to cache
	typedef struct packed {
		logic [3:0]  response; // nonzero tag on accept, zero on refuse
		logic [3:0]  tag;      // nonzero only in the cycle load data returns
		logic [63:0] data;
	} mem_rsp_t;

	// one cache line as stored in the array
	typedef struct packed {
		logic [63:0]         data;
		logic [tag_bits-1:0] tag;
		logic                valid;
		logic                dirty; // line differs from memory
	} line_t;

endpackage

// ==== source/dcache_array.sv ====
module dcache_array (
	input  logic                              clock,
	input  logic                              reset,
	input  logic [dcache_pkg::index_bits-1:0] index,   // line to read and write
	input  logic                              wr_en,
	input  dcache_pkg::line_t                 wr_line,
	output dcache_pkg::line_t                 rd_line  // line at index, same cycle
);

	// direct-mapped storage, one entry per index
	dcache_pkg::line_t lines [dcache_pkg::cache_lines];

	// reset wipes every entry so valid and dirty start clear
	// a write replaces the whole line at once
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < dcache_pkg::cache_lines; i++) begin
				lines[i] <= '0;
			end
		end else if (wr_en) begin
			lines[index] <= wr_line; // data, tag, valid and dirty together
		end
	end

	// combinational read
	// the controller does tag compare and victim pick off this in the
	// same cycle the index is presented
	assign rd_line = lines[index];

endmodule

// ==== source/dcache_ctrl.sv ====
module dcache_ctrl (
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              req,     // four-phase request
	input  dcache_pkg::cpu_req_t              cpu_req,
	output logic                              ack,
	output dcache_pkg::cpu_rsp_t              cpu_rsp,
	output dcache_pkg::mem_req_t              mem_req,
	input  dcache_pkg::mem_rsp_t              mem_rsp,
	output logic [dcache_pkg::index_bits-1:0] index,
	output logic                              wr_en,
	output dcache_pkg::line_t                 wr_line,
	input  dcache_pkg::line_t                 rd_line
);

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_wb_req,     // sending dirty victim to memory
		st_fetch_req,  // sending load of the missed block
		st_fetch_wait, // waiting for the memory tag to come back
		st_respond     // ack high until req drops
	} state_e;

	state_e            state;
	state_e            state_next;
	logic [3:0]        mem_tag;   // tag of the outstanding fill, zero when none
	logic [63:0]       rsp_data;  // load result held for the processor
	logic              hit;
	logic              victim_dirty;
	logic              is_store;
	logic              accepted;  // memory took the current request
	logic              fill_ready;
	dcache_pkg::addr_u victim_addr;
	dcache_pkg::addr_u fetch_addr;

	// request is held by the processor, so decode it straight off the port
	assign is_store = cpu_req.command == dcache_pkg::bus_store;
	assign index    = cpu_req.addr.fields.index;

	assign hit          = rd_line.valid && (rd_line.tag == cpu_req.addr.fields.tag);
	assign victim_dirty = rd_line.valid && rd_line.dirty; // needs write-back before reuse
	assign accepted     = mem_rsp.response != 4'h0;
	assign fill_ready   = (mem_tag != 4'h0) && (mem_rsp.tag == mem_tag);

	// block addresses, offset forced to zero
	always_comb begin
		victim_addr.fields.tag    = rd_line.tag; // where the old line lives
		victim_addr.fields.index  = index;
		victim_addr.fields.offset = '0;
		fetch_addr.fields.tag     = cpu_req.addr.fields.tag;
		fetch_addr.fields.index   = index;
		fetch_addr.fields.offset  = '0;
	end

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (req) state_next = st_lookup;
			end
			st_lookup: begin
				// store over a clean or empty line allocates right here
				if (hit || (is_store && !victim_dirty)) state_next = st_respond;
				else if (victim_dirty) state_next = st_wb_req;
				else state_next = st_fetch_req;
			end
			st_wb_req: begin
				// refused request just stays put
				if (accepted) state_next = is_store ? st_respond : st_fetch_req;
			end
			st_fetch_req: begin
				if (accepted) state_next = st_fetch_wait;
			end
			st_fetch_wait: begin
				if (fill_ready) state_next = st_respond;
			end
			st_respond: begin
				if (!req) state_next = st_idle; // ack falls on this edge
			end
			default: state_next = st_idle;
		endcase
	end

	// array writes
	// every store leaves the line valid and dirty, a fill leaves it clean
	always_comb begin
		wr_en         = 1'b0;
		wr_line.data  = cpu_req.data;
		wr_line.tag   = cpu_req.addr.fields.tag;
		wr_line.valid = 1'b1;
		wr_line.dirty = 1'b1;
		case (state)
			st_lookup:     wr_en = is_store && (hit || !victim_dirty);
			st_wb_req:     wr_en = is_store && accepted; // victim safe in memory now
			st_fetch_wait: begin
				wr_en         = fill_ready;
				wr_line.data  = mem_rsp.data;
				wr_line.dirty = 1'b0;
			end
			default: wr_en = 1'b0;
		endcase
	end

	// memory request, only driven in the two request states
	always_comb begin
		mem_req.command = dcache_pkg::bus_none;
		mem_req.addr    = fetch_addr.raw;
		mem_req.data    = rd_line.data; // victim data for write-back
		case (state)
			st_wb_req: begin
				mem_req.command = dcache_pkg::bus_store;
				mem_req.addr    = victim_addr.raw;
			end
			st_fetch_req: mem_req.command = dcache_pkg::bus_load;
			default:      mem_req.command = dcache_pkg::bus_none;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	// remember which memory tag carries our fill
	always_ff @(posedge clock) begin
		if (reset) begin
			mem_tag <= 4'h0;
		end else if (state == st_fetch_req && accepted) begin
			mem_tag <= mem_rsp.response;
		end else if (state == st_fetch_wait && fill_ready) begin
			mem_tag <= 4'h0; // fill done
		end
	end

	always_ff @(posedge clock) begin
		if (state == st_lookup && hit) begin
			rsp_data <= rd_line.data; // hit load
		end else if (state == st_fetch_wait && fill_ready) begin
			rsp_data <= mem_rsp.data; // load miss
		end
	end

	assign ack          = state == st_respond;
	assign cpu_rsp.data = rsp_data;

endmodule

// ==== source/dmem.sv ====
module dmem #(
	parameter int mem_latency = 4 // edges from acceptance to load data
) (
	input  logic                 clock,
	input  logic                 reset,
	input  dcache_pkg::mem_req_t mem_req,
	output dcache_pkg::mem_rsp_t mem_rsp
);

	localparam int word_bits = dcache_pkg::addr_bits - dcache_pkg::offset_bits;
	localparam int mem_words = 2 ** word_bits; // 8192 blocks

	logic [63:0]          mem [mem_words];
	logic [3:0]           pipe_tag [mem_latency];  // zero marks an empty slot
	logic [63:0]          pipe_data [mem_latency];
	logic [3:0]           next_tag;                // 1 to 15, never zero
	logic [3:0]           in_flight;               // loads still in the pipe
	logic                 accept;
	logic                 is_load;
	logic                 is_store;
	logic                 retire;
	logic [word_bits-1:0] word;
	dcache_pkg::addr_u    req_addr;

	assign req_addr = mem_req.addr;
	assign word     = req_addr.raw[dcache_pkg::addr_bits-1:dcache_pkg::offset_bits];

	assign is_load  = mem_req.command == dcache_pkg::bus_load;
	assign is_store = mem_req.command == dcache_pkg::bus_store;
	// refuse only once all 15 tags are out
	assign accept   = (mem_req.command != dcache_pkg::bus_none) && (in_flight != 4'd15);
	assign retire   = pipe_tag[mem_latency-1] != 4'h0;

	// acceptance is answered in the same cycle
	assign mem_rsp.response = accept ? next_tag : 4'h0;
	assign mem_rsp.tag      = pipe_tag[mem_latency-1];
	assign mem_rsp.data     = pipe_data[mem_latency-1];

	// contents start at zero, stores land on the acceptance edge
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < mem_words; i++) begin
				mem[i] <= '0;
			end
		end else if (accept && is_store) begin
			mem[word] <= mem_req.data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			next_tag <= 4'h1;
		end else if (accept) begin
			next_tag <= (next_tag == 4'd15) ? 4'h1 : next_tag + 4'h1; // skip zero
		end
	end

	// count loads entering and leaving the pipe
	always_ff @(posedge clock) begin
		if (reset) begin
			in_flight <= 4'h0;
		end else begin
			case ({accept && is_load, retire})
				2'b10:   in_flight <= in_flight + 4'h1;
				2'b01:   in_flight <= in_flight - 4'h1;
				default: in_flight <= in_flight; // both or neither
			endcase
		end
	end

	// latency pipe, one slot per edge
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < mem_latency; i++) begin
				pipe_tag[i] <= 4'h0;
			end
		end else begin
			pipe_tag[0] <= (accept && is_load) ? next_tag : 4'h0;
			for (int i = 1; i < mem_latency; i++) begin
				pipe_tag[i] <= pipe_tag[i-1];
			end
		end
	end

	// data rides alongside its tag, meaningless where the tag is zero
	always_ff @(posedge clock) begin
		pipe_data[0] <= mem[word];
		for (int i = 1; i < mem_latency; i++) begin
			pipe_data[i] <= pipe_data[i-1];
		end
	end

endmodule

// ==== source/dcache_subsystem.sv ====
module dcache_subsystem #(
	parameter int mem_latency = 4
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 req,
	input  dcache_pkg::cpu_req_t cpu_req,
	output logic                 ack,
	output dcache_pkg::cpu_rsp_t cpu_rsp
);

	dcache_pkg::mem_req_t              mem_req;
	dcache_pkg::mem_rsp_t              mem_rsp;
	logic [dcache_pkg::index_bits-1:0] index;
	logic                              wr_en;
	dcache_pkg::line_t                 wr_line;
	dcache_pkg::line_t                 rd_line;

	dcache_ctrl dcache_ctrl_i (
		.clock   (clock),
		.reset   (reset),
		.req     (req),
		.cpu_req (cpu_req),
		.ack     (ack),
		.cpu_rsp (cpu_rsp),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp),
		.index   (index),
		.wr_en   (wr_en),
		.wr_line (wr_line),
		.rd_line (rd_line)
	);

	dcache_array dcache_array_i (
		.clock   (clock),
		.reset   (reset),
		.index   (index),
		.wr_en   (wr_en),
		.wr_line (wr_line),
		.rd_line (rd_line)
	);

	// backing memory, latency set here
	dmem #(
		.mem_latency (mem_latency)
	) dmem_i (
		.clock   (clock),
		.reset   (reset),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

endmodule

// ==== test/dcache_tb.sv ====
module dcache_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int timeout_cycles = 200; // longest miss is a write-back plus a fetch

	logic                 clock = 1'b0;
	logic                 reset;
	logic                 req;
	dcache_pkg::cpu_req_t cpu_req;
	logic                 ack;
	dcache_pkg::cpu_rsp_t cpu_rsp;

	int     value_errors;
	int     protocol_errors;
	int     timeouts;
	integer seed;

	// blocks written so far, keyed by block number
	logic [63:0] model_mem [logic [12:0]];

	dcache_subsystem #(
		.mem_latency (4)
	) dcache_subsystem_i (
		.clock   (clock),
		.reset   (reset),
		.req     (req),
		.cpu_req (cpu_req),
		.ack     (ack),
		.cpu_rsp (cpu_rsp)
	);

	always #50 clock = ~clock;

	// four-phase rules, checked on every edge
	assert property (@(posedge clock) reset |=> !ack)
		else begin
			protocol_errors++;
			$display("ack was high right after a reset edge");
		end
	assert property (@(posedge clock) disable iff (reset) (!req && !ack) |=> !ack)
		else begin
			protocol_errors++;
			$display("ack rose while req was low");
		end
	assert property (@(posedge clock) disable iff (reset) (ack && req) |=> ack)
		else begin
			protocol_errors++;
			$display("ack dropped before req was released");
		end
	assert property (@(posedge clock) disable iff (reset) (ack && !req) |=> !ack)
		else begin
			protocol_errors++;
			$display("ack stayed high after req was sampled low");
		end

	function automatic logic [63:0] read_model(input logic [15:0] addr);
		if (model_mem.exists(addr[15:3])) return model_mem[addr[15:3]];
		return '0; // never written, memory starts at zero
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		assert (actual === expected)
			else begin
				value_errors++;
				$display("FAILED %s expected %h actual %h", name, expected, actual);
			end
	endtask

	// one full req/ack transaction, cycles counts falling edges until ack
	task automatic transfer(input dcache_pkg::bus_cmd_e cmd, input logic [15:0] addr,
			input logic [63:0] data, output logic [63:0] rdata, output int cycles);
		int waited;
		rdata  = '0;
		cycles = 0;
		if (timeouts != 0) return; // bus already stuck
		@(negedge clock);
		cpu_req.command  = cmd;
		cpu_req.addr.raw = addr;
		cpu_req.data     = data;
		req              = 1'b1;
		waited           = 0;
		while (!ack && waited < timeout_cycles) begin
			@(negedge clock);
			waited++;
		end
		if (!ack) begin
			timeouts++;
			$display("handshake timed out waiting for ack to rise, address %h", addr);
			req = 1'b0;
			return;
		end
		cycles = waited;
		rdata  = cpu_rsp.data; // valid while ack is high
		@(negedge clock); // req stays up one more edge, ack has to hold
		req    = 1'b0;
		cpu_req.command = dcache_pkg::bus_none;
		waited = 0;
		while (ack && waited < timeout_cycles) begin
			@(negedge clock);
			waited++;
		end
		if (ack) begin
			timeouts++;
			$display("handshake timed out waiting for ack to fall, address %h", addr);
		end
	endtask

	task automatic store_block(input logic [15:0] addr, input logic [63:0] data,
			output int cycles);
		logic [63:0] unused;
		transfer(dcache_pkg::bus_store, addr, data, unused, cycles);
		model_mem[addr[15:3]] = data;
	endtask

	task automatic load_and_check(input string name, input logic [15:0] addr,
			output int cycles);
		logic [63:0] got;
		transfer(dcache_pkg::bus_load, addr, '0, got, cycles);
		check_value(name, read_model(addr), got);
	endtask

	initial begin
		logic [15:0] addr;
		logic [15:0] addr_c;
		logic [15:0] addr_d;
		logic [15:0] addr_e;
		logic [63:0] data;
		logic [31:0] r;
		int          cycles;
		int          total;
		value_errors    = 0;
		protocol_errors = 0;
		timeouts        = 0;
		seed            = 32'h3751;
		reset           = 1'b1;
		req             = 1'b0;
		cpu_req         = '0;

		// eight edges of reset, ack watched throughout
		for (int i = 0; i < 8; i++) begin
			@(negedge clock);
			check_value("ack in reset", 64'h0, {63'h0, ack});
		end
		reset = 1'b0;
		repeat (4) begin
			@(negedge clock);
			check_value("ack idle", 64'h0, {63'h0, ack});
		end

		// fresh block, then store and a hit load
		addr = {8'h12, 5'd6, 3'd0};
		load_and_check("unwritten load", addr, cycles);
		store_block(addr, 64'h0123_4567_89ab_cdef, cycles);
		check_value("store hit latency", 64'd2, 64'(cycles)); // line was filled just before
		load_and_check("load after store", addr, cycles);
		check_value("load hit latency", 64'd2, 64'(cycles));

		// same index, two tags, A must survive eviction
		store_block({8'h01, 5'd5, 3'd0}, 64'haaaa_0000_1111_aaaa, cycles);
		store_block({8'h02, 5'd5, 3'd2}, 64'hbbbb_2222_3333_bbbb, cycles); // offset ignored
		load_and_check("evicted A", {8'h01, 5'd5, 3'd0}, cycles);
		load_and_check("evicted B", {8'h02, 5'd5, 3'd0}, cycles);

		// store miss over a clean line
		addr_c = {8'h31, 5'd9, 3'd0};
		addr_d = {8'h32, 5'd9, 3'd0};
		addr_e = {8'h33, 5'd9, 3'd0};
		store_block(addr_c, 64'hc0c0_c0c0_0000_0001, cycles);
		store_block(addr_d, 64'hd0d0_d0d0_0000_0002, cycles); // c goes to memory
		load_and_check("refill C", addr_c, cycles); // line now clean
		store_block(addr_e, 64'he0e0_e0e0_0000_0003, cycles);
		check_value("clean store miss latency", 64'd2, 64'(cycles)); // no fetch, no write-back
		load_and_check("clean victim C", addr_c, cycles);
		load_and_check("allocated E", addr_e, cycles);
		load_and_check("older D", addr_d, cycles);

		// random mix over 4 tags and 4 indices
		for (int n = 0; n < 200; n++) begin
			r    = $random(seed);
			addr = {8'h20 | {6'h0, r[2:1]}, {3'h0, r[4:3]}, r[7:5]};
			if (r[0]) begin
				data = {$random(seed), $random(seed)};
				store_block(addr, data, cycles);
			end else begin
				load_and_check("random load", addr, cycles);
			end
		end

		repeat (2) @(negedge clock);
		total = value_errors + protocol_errors + timeouts;
		$display("errors: value %0d protocol %0d timeout %0d", value_errors,
			protocol_errors, timeouts);
		if (total == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== dcache.f ====
source/dcache_pkg.sv
source/dcache_array.sv
source/dcache_ctrl.sv
source/dmem.sv
source/dcache_subsystem.sv
test/dcache_tb.sv

// ==== Makefile ====
# Verilator build and run for the data-cache subsystem

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= dcache_tb
LOG       ?= sim.log

FILELIST := dcache.f
SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := obj_dir/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when the file list or a source changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
